// ==== hw/gfx_cfg.svh ====
`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

// frame geometry, one 32-bit word per pixel

// pixels per line, address is row times this plus column
`define GFX_FB_WIDTH 256

// word address width, 512 lines of 256 pixels
`define GFX_ADDR_W 17

// memory word and pixel width
`define GFX_DATA_W 32

// cycles a requesting fetcher may go without a grant before it is forced in
`define GFX_FETCH_GAP 1

`endif

// ==== hw/gfx_pkg.sv ====
`include "gfx_cfg.svh"

package gfx_pkg;

   // word address into the frame memory
   typedef logic [`GFX_ADDR_W-1:0] addr_t;

   // one pixel, one memory word
   typedef logic [`GFX_DATA_W-1:0] pixel_t;

   // per-byte write enable, all zero means read
   typedef logic [`GFX_DATA_W/8-1:0] ben_t;

   // x or y coordinate, also used for widths, heights and run lengths
   typedef logic [8:0] coord_t;

   // one-hot grant, bit 0 fetcher, bit 1 fill, bit 2 outline
   typedef logic [2:0] client_t;

   // shared by both rectangle engines
   // drain holds busy while the last write travels to memory
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN
   } draw_state_t;

endpackage

// ==== hw/mem_req_if.sv ====
`timescale 1ns/100ps

// request channel between one memory client and the arbiter
interface mem_req_if;

   // request side, driven by the client
   gfx_pkg::addr_t  addr;
   gfx_pkg::pixel_t wrdata;
   // byte enables, zero means read
   gfx_pkg::ben_t   op;
   logic            rts;

   // grant side, driven by the arbiter
   logic            rtr;
   // read data for this client sits on the broadcast bus
   logic            rd_valid;

   modport client (
      output addr, wrdata, op, rts,
      input  rtr, rd_valid
   );

   modport arbiter (
      input  addr, wrdata, op, rts,
      output rtr, rd_valid
   );

endinterface

// ==== hw/rect_fill_engine.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module rect_fill_engine (
   input  logic            clk,
   input  logic            rst_,
   input  logic            start,
   input  gfx_pkg::coord_t x0,
   input  gfx_pkg::coord_t y0,
   input  gfx_pkg::coord_t w,
   input  gfx_pkg::coord_t h,
   input  gfx_pkg::pixel_t color,
   output logic            busy,
   mem_req_if.client       mem
);

   gfx_pkg::draw_state_t state;

   // command latched on start
   gfx_pkg::coord_t x0_q;
   gfx_pkg::coord_t y0_q;
   gfx_pkg::coord_t w_q;
   gfx_pkg::coord_t h_q;
   gfx_pkg::pixel_t color_q;

   // offset of the current pixel inside the rectangle
   gfx_pkg::coord_t cnt_x;
   gfx_pkg::coord_t cnt_y;
   gfx_pkg::coord_t cur_x;
   gfx_pkg::coord_t cur_y;

   logic xfer;
   logic last_col;
   logic last_row;

   assign xfer     = mem.rts & mem.rtr;
   assign last_col = (cnt_x == w_q - 1'b1);
   assign last_row = (cnt_y == h_q - 1'b1);
   // coordinates wrap, no clipping at the frame edge
   assign cur_x    = x0_q + cnt_x;
   assign cur_y    = y0_q + cnt_y;

   // one full-word write per pixel
   assign mem.rts    = (state == gfx_pkg::RUN);
   assign mem.addr   = gfx_pkg::addr_t'(cur_y * `GFX_FB_WIDTH + cur_x);
   assign mem.wrdata = color_q;
   assign mem.op     = '1;

   assign busy = (state != gfx_pkg::IDLE);

   always_ff @(posedge clk or negedge rst_) begin
      if (!rst_) begin
         state <= gfx_pkg::IDLE;
         cnt_x <= '0;
         cnt_y <= '0;
      end else begin
         case (state)
            gfx_pkg::IDLE: begin
               cnt_x <= '0;
               cnt_y <= '0;
               // empty rectangle just pulses busy
               if (start && (w == '0 || h == '0)) begin
                  state <= gfx_pkg::DRAIN;
               end else if (start) begin
                  state <= gfx_pkg::RUN;
               end
            end
            gfx_pkg::RUN: begin
               // step x first, then y, only when the write is taken
               if (xfer && last_col) begin
                  cnt_x <= '0;
                  cnt_y <= cnt_y + 1'b1;
                  if (last_row) begin
                     state <= gfx_pkg::DRAIN;
                  end
               end else if (xfer) begin
                  cnt_x <= cnt_x + 1'b1;
               end
            end
            default: begin
               state <= gfx_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == gfx_pkg::IDLE && start) begin
         x0_q    <= x0;
         y0_q    <= y0;
         w_q     <= w;
         h_q     <= h;
         color_q <= color;
      end
   end

endmodule

// ==== hw/rect_outline_engine.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module rect_outline_engine (
   input  logic            clk,
   input  logic            rst_,
   input  logic            start,
   input  gfx_pkg::coord_t x0,
   input  gfx_pkg::coord_t y0,
   input  gfx_pkg::coord_t w,
   input  gfx_pkg::coord_t h,
   input  gfx_pkg::pixel_t color,
   output logic            busy,
   mem_req_if.client       mem
);

   gfx_pkg::draw_state_t state;

   gfx_pkg::coord_t x0_q;
   gfx_pkg::coord_t y0_q;
   gfx_pkg::coord_t w_q;
   gfx_pkg::coord_t h_q;
   gfx_pkg::pixel_t color_q;

   gfx_pkg::coord_t cnt_x;
   gfx_pkg::coord_t cnt_y;
   gfx_pkg::coord_t cur_x;
   gfx_pkg::coord_t cur_y;

   logic xfer;
   logic last_col;
   logic last_row;
   logic edge_row;

   assign xfer     = mem.rts & mem.rtr;
   assign last_col = (cnt_x == w_q - 1'b1);
   assign last_row = (cnt_y == h_q - 1'b1);
   // top and bottom rows are written in full
   assign edge_row = (cnt_y == '0) || last_row;
   assign cur_x    = x0_q + cnt_x;
   assign cur_y    = y0_q + cnt_y;

   // only border pixels are ever visited, so every step is a write
   assign mem.rts    = (state == gfx_pkg::RUN);
   assign mem.addr   = gfx_pkg::addr_t'(cur_y * `GFX_FB_WIDTH + cur_x);
   assign mem.wrdata = color_q;
   assign mem.op     = '1;

   assign busy = (state != gfx_pkg::IDLE);

   always_ff @(posedge clk or negedge rst_) begin
      if (!rst_) begin
         state <= gfx_pkg::IDLE;
         cnt_x <= '0;
         cnt_y <= '0;
      end else begin
         case (state)
            gfx_pkg::IDLE: begin
               cnt_x <= '0;
               cnt_y <= '0;
               if (start && (w == '0 || h == '0)) begin
                  state <= gfx_pkg::DRAIN;
               end else if (start) begin
                  state <= gfx_pkg::RUN;
               end
            end
            gfx_pkg::RUN: begin
               // width 1 makes first and last column the same pixel,
               // last_col wins so it is written once
               if (xfer && last_col) begin
                  cnt_x <= '0;
                  cnt_y <= cnt_y + 1'b1;
                  if (last_row) begin
                     state <= gfx_pkg::DRAIN;
                  end
               end else if (xfer && !edge_row) begin
                  // interior row, jump from left edge straight to right edge
                  cnt_x <= w_q - 1'b1;
               end else if (xfer) begin
                  cnt_x <= cnt_x + 1'b1;
               end
            end
            default: begin
               state <= gfx_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == gfx_pkg::IDLE && start) begin
         x0_q    <= x0;
         y0_q    <= y0;
         w_q     <= w;
         h_q     <= h;
         color_q <= color;
      end
   end

endmodule

// ==== hw/scan_fetcher.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module scan_fetcher (
   input  logic            clk,
   input  logic            rst_,
   input  logic            fetch_start,
   input  gfx_pkg::coord_t fetch_x,
   input  gfx_pkg::coord_t fetch_y,
   input  gfx_pkg::coord_t fetch_len,
   output logic            fetch_busy,
   output gfx_pkg::pixel_t pix_data,
   output logic            pix_valid,
   input  gfx_pkg::pixel_t bcast_data,
   mem_req_if.client       mem
);

   gfx_pkg::coord_t x_q;
   gfx_pkg::coord_t y_q;
   gfx_pkg::coord_t len_q;
   // reads issued and pixels handed out, kept apart so reads overlap
   gfx_pkg::coord_t iss_cnt;
   gfx_pkg::coord_t ret_cnt;
   gfx_pkg::coord_t cur_x;
   logic            xfer;

   assign xfer  = mem.rts & mem.rtr;
   assign cur_x = x_q + iss_cnt;

   // keep issuing until every read of the run has gone out
   assign mem.rts    = fetch_busy && (iss_cnt != len_q);
   assign mem.addr   = gfx_pkg::addr_t'(y_q * `GFX_FB_WIDTH + cur_x);
   assign mem.wrdata = '0;
   assign mem.op     = '0;

   always_ff @(posedge clk or negedge rst_) begin
      if (!rst_) begin
         fetch_busy <= 1'b0;
         pix_valid  <= 1'b0;
         iss_cnt    <= '0;
         ret_cnt    <= '0;
      end else begin
         // fixed read latency keeps returns in issue order
         pix_valid <= mem.rd_valid;
         if (!fetch_busy) begin
            iss_cnt <= '0;
            ret_cnt <= '0;
            // zero length run does nothing
            if (fetch_start && fetch_len != '0) begin
               fetch_busy <= 1'b1;
            end
         end else begin
            if (xfer) begin
               iss_cnt <= iss_cnt + 1'b1;
            end
            if (pix_valid) begin
               ret_cnt <= ret_cnt + 1'b1;
               // drop busy right after the last pixel
               if (ret_cnt == len_q - 1'b1) begin
                  fetch_busy <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!fetch_busy && fetch_start) begin
         x_q   <= fetch_x;
         y_q   <= fetch_y;
         len_q <= fetch_len;
      end
      if (mem.rd_valid) begin
         pix_data <= bcast_data;
      end
   end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module mem_arbiter (
   input  logic             clk,
   input  logic             rst_,
   mem_req_if.arbiter       fetch,
   mem_req_if.arbiter       fill,
   mem_req_if.arbiter       outline,
   input  logic             soft_req,
   input  gfx_pkg::addr_t   soft_addr,
   input  gfx_pkg::pixel_t  soft_data,
   input  gfx_pkg::ben_t    soft_ben,
   output gfx_pkg::ben_t    mem_ben,
   output gfx_pkg::addr_t   mem_addr,
   output gfx_pkg::pixel_t  mem_wdata,
   output gfx_pkg::client_t sel
);

   // wide enough to count well past the fetch gap
   localparam int WAIT_W = 4;

   gfx_pkg::client_t req;
   gfx_pkg::client_t xfer;
   gfx_pkg::client_t rr_ptr;
   gfx_pkg::client_t rr_rot;
   gfx_pkg::client_t fixed_pick;
   gfx_pkg::client_t sel_nxt;
   // owner of a read, one stage per cycle of memory latency
   gfx_pkg::client_t rd_own_q1;
   gfx_pkg::client_t rd_own_q2;

   logic [WAIT_W-1:0] wait_cnt;
   logic [WAIT_W-1:0] wait_nxt;
   logic              fetch_force;

   gfx_pkg::addr_t    win_addr;
   gfx_pkg::pixel_t   win_data;
   gfx_pkg::ben_t     win_op;

   assign req = {outline.rts, fill.rts, fetch.rts};

   // soft path owns the port in any cycle it asks, clients just stall
   assign fetch.rtr   = sel[0] & ~soft_req;
   assign fill.rtr    = sel[1] & ~soft_req;
   assign outline.rtr = sel[2] & ~soft_req;

   assign xfer = {outline.rtr & outline.rts, fill.rtr & fill.rts, fetch.rtr & fetch.rts};

   // next round-robin owner, fetcher after outline
   assign rr_rot = {rr_ptr[1:0], rr_ptr[2]};

   // fallback when the owner has nothing to do
   always_comb begin
      if (req[0]) begin
         fixed_pick = 3'b001;
      end else if (req[1]) begin
         fixed_pick = 3'b010;
      end else if (req[2]) begin
         fixed_pick = 3'b100;
      end else begin
         fixed_pick = 3'b000;
      end
   end

   // cycles the fetcher has been requesting without a transfer
   always_comb begin
      if (xfer[0] || !req[0]) begin
         wait_nxt = '0;
      end else if (wait_cnt == '1) begin
         wait_nxt = wait_cnt;
      end else begin
         wait_nxt = wait_cnt + 1'b1;
      end
   end

   assign fetch_force = req[0] && (wait_nxt >= WAIT_W'(`GFX_FETCH_GAP));

   always_comb begin
      if (fetch_force) begin
         sel_nxt = 3'b001;
      end else if ((req & rr_ptr) != '0) begin
         sel_nxt = rr_ptr;
      end else begin
         sel_nxt = fixed_pick;
      end
   end

   // command of the granted client
   always_comb begin
      case (sel)
         3'b010: begin
            win_addr = fill.addr;
            win_data = fill.wrdata;
            win_op   = fill.op;
         end
         3'b100: begin
            win_addr = outline.addr;
            win_data = outline.wrdata;
            win_op   = outline.op;
         end
         default: begin
            win_addr = fetch.addr;
            win_data = fetch.wrdata;
            win_op   = fetch.op;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_) begin
      if (!rst_) begin
         sel       <= '0;
         rr_ptr    <= 3'b001;
         wait_cnt  <= '0;
         mem_ben   <= '0;
         rd_own_q1 <= '0;
         rd_own_q2 <= '0;
      end else begin
         sel       <= sel_nxt;
         wait_cnt  <= wait_nxt;
         rd_own_q2 <= rd_own_q1;
         // a forced fetch slot does not use up anyone's turn
         if (!fetch_force) begin
            rr_ptr <= rr_rot;
         end
         if (soft_req) begin
            mem_ben   <= soft_ben;
            rd_own_q1 <= '0;
         end else if (xfer != '0) begin
            mem_ben   <= win_op;
            rd_own_q1 <= (win_op == '0) ? xfer : '0;
         end else begin
            mem_ben   <= '0;
            rd_own_q1 <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (soft_req) begin
         mem_addr  <= soft_addr;
         mem_wdata <= soft_data;
      end else begin
         mem_addr  <= win_addr;
         mem_wdata <= win_data;
      end
   end

   // read data is on the bus two cycles after the transfer
   assign fetch.rd_valid   = rd_own_q2[0];
   assign fill.rd_valid    = rd_own_q2[1];
   assign outline.rd_valid = rd_own_q2[2];

endmodule

// ==== hw/frame_bram.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module frame_bram (
   input  logic                       clk,
   input  logic [`GFX_DATA_W/8-1:0]   ben,
   input  logic [`GFX_ADDR_W-1:0]     addr,
   input  logic [`GFX_DATA_W-1:0]     wdata,
   output logic [`GFX_DATA_W-1:0]     rdata
);

   localparam int BYTES = `GFX_DATA_W / 8;
   localparam int DEPTH = 1 << `GFX_ADDR_W;

   // one word per pixel
   logic [`GFX_DATA_W-1:0] mem [0:DEPTH-1];

   always_ff @(posedge clk) begin
      // only the enabled bytes change
      for (int i = 0; i < BYTES; i++) begin
         if (ben[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
      // no enables set means a read, data out next cycle
      if (ben == '0) begin
         rdata <= mem[addr];
      end
   end

endmodule

// ==== hw/gfx_mem_top.sv ====
`timescale 1ns/100ps

module gfx_mem_top (
   input  logic            clk,
   input  logic            rst_,
   input  logic            fill_start,
   input  gfx_pkg::coord_t fill_x0,
   input  gfx_pkg::coord_t fill_y0,
   input  gfx_pkg::coord_t fill_w,
   input  gfx_pkg::coord_t fill_h,
   input  gfx_pkg::pixel_t fill_color,
   input  logic            outline_start,
   input  gfx_pkg::coord_t outline_x0,
   input  gfx_pkg::coord_t outline_y0,
   input  gfx_pkg::coord_t outline_w,
   input  gfx_pkg::coord_t outline_h,
   input  gfx_pkg::pixel_t outline_color,
   input  logic            soft_req,
   input  gfx_pkg::addr_t  soft_addr,
   input  gfx_pkg::pixel_t soft_data,
   input  gfx_pkg::ben_t   soft_ben,
   input  logic            fetch_start,
   input  gfx_pkg::coord_t fetch_x,
   input  gfx_pkg::coord_t fetch_y,
   input  gfx_pkg::coord_t fetch_len,
   output gfx_pkg::pixel_t pix_data,
   output logic            pix_valid,
   output logic            fill_busy,
   output logic            outline_busy,
   output logic            fetch_busy
);

   // memory port, registered in the arbiter
   gfx_pkg::ben_t   mem_ben;
   gfx_pkg::addr_t  mem_addr;
   gfx_pkg::pixel_t mem_wdata;
   // read data fans out to every client
   gfx_pkg::pixel_t bcast_data;

   mem_req_if fetch_if ();
   mem_req_if fill_if ();
   mem_req_if outline_if ();

   rect_fill_engine i_fill (
      .clk   (clk),
      .rst_  (rst_),
      .start (fill_start),
      .x0    (fill_x0),
      .y0    (fill_y0),
      .w     (fill_w),
      .h     (fill_h),
      .color (fill_color),
      .busy  (fill_busy),
      .mem   (fill_if.client)
   );

   rect_outline_engine i_outline (
      .clk   (clk),
      .rst_  (rst_),
      .start (outline_start),
      .x0    (outline_x0),
      .y0    (outline_y0),
      .w     (outline_w),
      .h     (outline_h),
      .color (outline_color),
      .busy  (outline_busy),
      .mem   (outline_if.client)
   );

   scan_fetcher i_fetch (
      .clk         (clk),
      .rst_        (rst_),
      .fetch_start (fetch_start),
      .fetch_x     (fetch_x),
      .fetch_y     (fetch_y),
      .fetch_len   (fetch_len),
      .fetch_busy  (fetch_busy),
      .pix_data    (pix_data),
      .pix_valid   (pix_valid),
      .bcast_data  (bcast_data),
      .mem         (fetch_if.client)
   );

   // grant vector only watched by the bound checks
   mem_arbiter i_arb (
      .clk       (clk),
      .rst_      (rst_),
      .fetch     (fetch_if.arbiter),
      .fill      (fill_if.arbiter),
      .outline   (outline_if.arbiter),
      .soft_req  (soft_req),
      .soft_addr (soft_addr),
      .soft_data (soft_data),
      .soft_ben  (soft_ben),
      .mem_ben   (mem_ben),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .sel       ()
   );

   frame_bram i_bram (
      .clk   (clk),
      .ben   (mem_ben),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (bcast_data)
   );

endmodule

// ==== verification/gfx_mem_assertions.sv ====
`timescale 1ns/100ps

// arbiter checks, bound into every mem_arbiter
module gfx_mem_assertions (
   input logic             clk,
   input logic             rst_,
   input gfx_pkg::client_t sel,
   input logic             soft_req,
   input gfx_pkg::ben_t    mem_ben,
   input gfx_pkg::client_t rtr,
   input gfx_pkg::client_t rd_valid
);

   // at most one client granted
   sel_onehot: assert property (@(posedge clk) disable iff (!rst_) $onehot0(sel))
      else $error("arbiter grant vector is not one-hot: %b", sel);

   // soft write owns the port, no client may transfer
   soft_blocks_clients: assert property (@(posedge clk) disable iff (!rst_)
      soft_req |-> (rtr == '0))
      else $error("client rtr high while soft_req is high: %b", rtr);

   // second reset edge onward, registers have been cleared
   reset_quiet: assert property (@(posedge clk)
      (!rst_ && $past(!rst_)) |-> (sel == '0 && rtr == '0 && rd_valid == '0 && mem_ben == '0))
      else $error("arbiter outputs not quiet during reset");

endmodule

bind mem_arbiter gfx_mem_assertions i_arb_chk (
   .clk      (clk),
   .rst_     (rst_),
   .sel      (sel),
   .soft_req (soft_req),
   .mem_ben  (mem_ben),
   .rtr      ({outline.rtr, fill.rtr, fetch.rtr}),
   .rd_valid ({outline.rd_valid, fill.rd_valid, fetch.rd_valid})
);

// ==== verification/tb_gfx_mem.sv ====
`timescale 1ns/100ps
`include "gfx_cfg.svh"

module tb_gfx_mem;

   // cycles a wait may take before the run is abandoned
   localparam int IDLE_TIMEOUT = 5000;
   // inputs change this long after the rising edge
   localparam int DRIVE_DELAY  = 10;

   logic            clk;
   logic            rst_;
   logic            fill_start;
   gfx_pkg::coord_t fill_x0;
   gfx_pkg::coord_t fill_y0;
   gfx_pkg::coord_t fill_w;
   gfx_pkg::coord_t fill_h;
   gfx_pkg::pixel_t fill_color;
   logic            outline_start;
   gfx_pkg::coord_t outline_x0;
   gfx_pkg::coord_t outline_y0;
   gfx_pkg::coord_t outline_w;
   gfx_pkg::coord_t outline_h;
   gfx_pkg::pixel_t outline_color;
   logic            soft_req;
   gfx_pkg::addr_t  soft_addr;
   gfx_pkg::pixel_t soft_data;
   gfx_pkg::ben_t   soft_ben;
   logic            fetch_start;
   gfx_pkg::coord_t fetch_x;
   gfx_pkg::coord_t fetch_y;
   gfx_pkg::coord_t fetch_len;
   gfx_pkg::pixel_t pix_data;
   logic            pix_valid;
   logic            fill_busy;
   logic            outline_busy;
   logic            fetch_busy;

   // pixels seen on the output and the values the input file wants
   gfx_pkg::pixel_t got_q[$];
   gfx_pkg::pixel_t exp_q[$];

   // commands staged by the input file until the next launch
   logic fill_pend;
   logic outline_pend;
   logic fetch_pend;
   logic fetch_check;

   int err_cnt       = 0;
   int test_cnt      = 0;
   int test_fail     = 0;
   int test_err_base = 0;
   bit abort         = 1'b0;

   gfx_mem_top i_dut (
      .clk           (clk),
      .rst_          (rst_),
      .fill_start    (fill_start),
      .fill_x0       (fill_x0),
      .fill_y0       (fill_y0),
      .fill_w        (fill_w),
      .fill_h        (fill_h),
      .fill_color    (fill_color),
      .outline_start (outline_start),
      .outline_x0    (outline_x0),
      .outline_y0    (outline_y0),
      .outline_w     (outline_w),
      .outline_h     (outline_h),
      .outline_color (outline_color),
      .soft_req      (soft_req),
      .soft_addr     (soft_addr),
      .soft_data     (soft_data),
      .soft_ben      (soft_ben),
      .fetch_start   (fetch_start),
      .fetch_x       (fetch_x),
      .fetch_y       (fetch_y),
      .fetch_len     (fetch_len),
      .pix_data      (pix_data),
      .pix_valid     (pix_valid),
      .fill_busy     (fill_busy),
      .outline_busy  (outline_busy),
      .fetch_busy    (fetch_busy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // outputs are registered, mid cycle they are settled
   always @(negedge clk) begin
      if (rst_ && pix_valid) begin
         got_q.push_back(pix_data);
         // every pixel must come out before fetch_busy drops
         assert (fetch_busy) else begin
            $display("ERROR t=%0t a pixel came out while fetch_busy was low", $time);
            err_cnt++;
         end
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // row major frame, no clipping so the address just wraps
   function automatic gfx_pkg::addr_t pixel_addr(input int x, input int y);
      return gfx_pkg::addr_t'(y * `GFX_FB_WIDTH + x);
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic expect_fields(input string op, input int n, input int want);
      assert (n == want) else begin
         $display("ERROR t=%0t input command %s has %0d values, needs %0d", $time, op, n, want);
         err_cnt++;
         abort = 1'b1;
      end
   endtask

   // soft path takes the port in the cycle it is raised
   task automatic soft_write(input int x, input int y, input gfx_pkg::pixel_t data,
                             input gfx_pkg::ben_t ben);
      soft_req  = 1'b1;
      soft_addr = pixel_addr(x, y);
      soft_data = data;
      soft_ben  = ben;
      next_cycle();
      soft_req  = 1'b0;
      soft_ben  = '0;
   endtask

   // all staged starts go out in the same cycle
   task automatic launch();
      fill_start    = fill_pend;
      outline_start = outline_pend;
      fetch_start   = fetch_pend;
      got_q.delete();
      next_cycle();
      fill_start    = 1'b0;
      outline_start = 1'b0;
      fetch_start   = 1'b0;
      fill_pend     = 1'b0;
      outline_pend  = 1'b0;
      fetch_pend    = 1'b0;
   endtask

   task automatic compare_pixels();
      int n;
      assert (got_q.size() == exp_q.size()) else begin
         $display("MISMATCH t=%0t pix_valid pulses got %0d expected %0d",
                  $time, got_q.size(), exp_q.size());
         err_cnt++;
      end
      n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      // order matters, pixel i belongs to address x + i
      for (int i = 0; i < n; i++) begin
         assert (got_q[i] === exp_q[i]) else begin
            $display("MISMATCH t=%0t pix_data[%0d] got %h expected %h",
                     $time, i, got_q[i], exp_q[i]);
            err_cnt++;
         end
      end
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      if (err_cnt == test_err_base) begin
         $display("test %s ok", name);
      end else begin
         $display("test %s failed with %0d errors", name, err_cnt - test_err_base);
         test_fail++;
      end
      test_err_base = err_cnt;
   endtask

   task automatic wait_idle(input string name);
      int cycles;
      cycles = 0;
      while ((fill_busy || outline_busy || fetch_busy) && cycles < IDLE_TIMEOUT) begin
         next_cycle();
         cycles++;
      end
      if (fill_busy || outline_busy || fetch_busy) begin
         $display("ERROR t=%0t test %s timed out, an engine or the fetcher stayed busy",
                  $time, name);
         err_cnt++;
         abort = 1'b1;
      end else if (fetch_check) begin
         compare_pixels();
      end
      fetch_check = 1'b0;
      finish_test(name);
   endtask

   task automatic run_file();
      int              fd;
      int              n;
      int              x;
      int              y;
      int              w;
      int              h;
      int              cnt;
      logic [31:0]     data;
      logic [31:0]     step;
      logic [31:0]     ben;
      string           op;
      string           name;
      logic [8*128-1:0] rest;
      fd = $fopen("verification/gfx_mem_input.txt", "r");
      assert (fd != 0) else begin
         $display("ERROR cannot open the stimulus file verification/gfx_mem_input.txt");
         err_cnt++;
         abort = 1'b1;
      end
      while (!abort && $fscanf(fd, "%s", op) == 1) begin
         if (op.substr(0, 0) == "#") begin
            n = $fgets(rest, fd);
         end else if (op == "C") begin
            // run of full-word soft writes, value steps along the line
            n = $fscanf(fd, "%d %d %d %h %h", x, y, cnt, data, step);
            expect_fields(op, n, 5);
            for (int i = 0; i < cnt; i++) begin
               soft_write(x + i, y, data + gfx_pkg::pixel_t'(i) * step, '1);
            end
         end else if (op == "S") begin
            n = $fscanf(fd, "%d %d %h %h", x, y, data, ben);
            expect_fields(op, n, 4);
            soft_write(x, y, data, gfx_pkg::ben_t'(ben));
         end else if (op == "F") begin
            n = $fscanf(fd, "%d %d %d %d %h", x, y, w, h, data);
            expect_fields(op, n, 5);
            fill_x0    = gfx_pkg::coord_t'(x);
            fill_y0    = gfx_pkg::coord_t'(y);
            fill_w     = gfx_pkg::coord_t'(w);
            fill_h     = gfx_pkg::coord_t'(h);
            fill_color = data;
            fill_pend  = 1'b1;
         end else if (op == "O") begin
            n = $fscanf(fd, "%d %d %d %d %h", x, y, w, h, data);
            expect_fields(op, n, 5);
            outline_x0    = gfx_pkg::coord_t'(x);
            outline_y0    = gfx_pkg::coord_t'(y);
            outline_w     = gfx_pkg::coord_t'(w);
            outline_h     = gfx_pkg::coord_t'(h);
            outline_color = data;
            outline_pend  = 1'b1;
         end else if (op == "R") begin
            n = $fscanf(fd, "%d %d %d", x, y, cnt);
            expect_fields(op, n, 3);
            fetch_x     = gfx_pkg::coord_t'(x);
            fetch_y     = gfx_pkg::coord_t'(y);
            fetch_len   = gfx_pkg::coord_t'(cnt);
            fetch_pend  = 1'b1;
            fetch_check = 1'b1;
            exp_q.delete();
         end else if (op == "E") begin
            n = $fscanf(fd, "%h %d %h", data, cnt, step);
            expect_fields(op, n, 3);
            for (int i = 0; i < cnt; i++) begin
               exp_q.push_back(data + gfx_pkg::pixel_t'(i) * step);
            end
         end else if (op == "G") begin
            launch();
         end else if (op == "W") begin
            n = $fscanf(fd, "%s", name);
            expect_fields(op, n, 1);
            wait_idle(name);
         end else begin
            $display("ERROR unknown command %s in the stimulus file", op);
            err_cnt++;
            abort = 1'b1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
   endtask

   initial begin
      rst_          = 1'b0;
      fill_start    = 1'b0;
      fill_x0       = '0;
      fill_y0       = '0;
      fill_w        = '0;
      fill_h        = '0;
      fill_color    = '0;
      outline_start = 1'b0;
      outline_x0    = '0;
      outline_y0    = '0;
      outline_w     = '0;
      outline_h     = '0;
      outline_color = '0;
      soft_req      = 1'b0;
      soft_addr     = '0;
      soft_data     = '0;
      soft_ben      = '0;
      fetch_start   = 1'b0;
      fetch_x       = '0;
      fetch_y       = '0;
      fetch_len     = '0;
      fill_pend     = 1'b0;
      outline_pend  = 1'b0;
      fetch_pend    = 1'b0;
      fetch_check   = 1'b0;

      repeat (5) @(posedge clk);
      #DRIVE_DELAY;
      rst_ = 1'b1;

      // everything quiet straight out of reset
      check_bit("fill_busy", fill_busy, 1'b0);
      check_bit("outline_busy", outline_busy, 1'b0);
      check_bit("fetch_busy", fetch_busy, 1'b0);
      check_bit("pix_valid", pix_valid, 1'b0);
      finish_test("reset_state");

      run_file();

      $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== verification/gfx_mem_input.txt ====
# C x y count data step | S x y data ben | F or O x y w h color | R x y len
# E value count step lists expected pixels | G launches staged starts | W name waits, checks
C 0 10 16 0a000000 1
R 0 10 16
E 0a000000 16 1
G
W reset_soft
C 0 11 16 0a0a0a0a 0
C 0 12 16 0a0a0a0a 0
F 4 11 6 3 c0c0c0c0
G
W fill_draw
R 3 12 8
E 0a0a0a0a 1 0
E c0c0c0c0 6 0
E 0a0a0a0a 1 0
G
W fill_check
O 4 11 6 3 0b0b0b0b
G
W outline_draw
R 3 12 8
E 0a0a0a0a 1 0
E 0b0b0b0b 1 0
E c0c0c0c0 4 0
E 0b0b0b0b 1 0
E 0a0a0a0a 1 0
G
W outline_mid_row
R 3 11 8
E 0a0a0a0a 1 0
E 0b0b0b0b 6 0
E 0a0a0a0a 1 0
G
W outline_top_row
C 18 21 28 00000000 0
C 18 23 28 00000000 0
F 20 20 5 2 f1f1f1f1
O 40 20 4 4 0d0d0d0d
R 0 10 16
E 0a000000 16 1
G
W concurrent
R 19 21 26
E 00000000 1 0
E f1f1f1f1 5 0
E 00000000 15 0
E 0d0d0d0d 1 0
E 00000000 2 0
E 0d0d0d0d 1 0
E 00000000 1 0
G
W concurrent_row21
R 19 23 26
E 00000000 21 0
E 0d0d0d0d 4 0
E 00000000 1 0
G
W concurrent_row23
C 0 40 4 12345678 0
F 60 30 8 8 22222222
G
S 0 40 aabbccdd 1
S 1 40 aabbccdd 6
S 2 40 aabbccdd 8
S 3 40 aabbccdd 5
W soft_during_fill
R 0 40 4
E 123456dd 1 0
E 12bbcc78 1 0
E aa345678 1 0
E 12bb56dd 1 0
G
W soft_merge
C 0 50 12 00000100 00000101
R 0 50 12
E 00000100 12 00000101
G
W pixel_order

// ==== build.f ====
+incdir+hw
hw/gfx_pkg.sv
hw/mem_req_if.sv
hw/rect_fill_engine.sv
hw/rect_outline_engine.sv
hw/scan_fetcher.sv
hw/mem_arbiter.sv
hw/frame_bram.sv
hw/gfx_mem_top.sv
verification/gfx_mem_assertions.sv
verification/tb_gfx_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the frame memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f build.f --top-module tb_gfx_mem -o tb_gfx_mem \
   || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/tb_gfx_mem)
echo "$out"

echo "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1
